// File: src/stream_sum_pkg.sv
`default_nettype none

package stream_sum_pkg;

    // ##############################
    // Widths
    // ##############################

    // Width of one stream word and of the running sum.
    localparam int DATA_W = 32;

    // Beat counts go up to 256, so one bit more than the length field.
    localparam int CNT_W = 9;

    // ##############################
    // Payload types
    // ##############################

    // Configured packet length. Zero stands for 256 beats.
    typedef logic [7:0] pkt_len_t;

    // One word of a packet, with the flag on its final beat.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } beat_t;

    // Per-packet result, the sum modulo 2^32 and the number of beats.
    typedef struct packed {
        logic [DATA_W-1:0] sum;
        logic [CNT_W-1:0]  beats;
    } result_t;

endpackage : stream_sum_pkg

`default_nettype wire

// File: src/axi_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Skid buffer with every port driven or received by a flop.
// Entry 0 is the head and feeds o_rd_data directly.
module axi_skid_buffer #(
    parameter type T     = stream_sum_pkg::beat_t,
    parameter int  SKID4 = 0
) (
    input  wire logic  i_axi_aclk,
    input  wire logic  i_axi_aresetn,

    // Write side.
    input  wire logic  i_wr_valid,
    output logic       o_wr_ready,
    input  wire T      i_wr_data,

    // Read side.
    output logic       o_rd_valid,
    input  wire logic  i_rd_ready,
    output logic [2:0] o_rd_count,
    output T           o_rd_data
);

    localparam int DEPTH = (SKID4 != 0) ? 4 : 2;

    logic       r_wr_ready;
    logic       r_rd_valid;
    logic [2:0] r_count;
    logic [2:0] w_next_count;
    logic [2:0] w_wr_idx;
    logic       w_wr_xfer;
    logic       w_rd_xfer;

    T r_mem       [DEPTH];
    T w_slot_next [DEPTH];

    assign w_wr_xfer = i_wr_valid & r_wr_ready;
    assign w_rd_xfer = r_rd_valid & i_rd_ready;

    // A word written while the head leaves lands one slot lower.
    assign w_wr_idx = w_rd_xfer ? (r_count - 3'd1) : r_count;

    // ##############################
    // Occupancy and handshake flops
    // ##############################

    always_comb begin
        w_next_count = r_count;
        if (w_wr_xfer && !w_rd_xfer) begin
            w_next_count = r_count + 3'd1;
        end else if (!w_wr_xfer && w_rd_xfer) begin
            w_next_count = r_count - 3'd1;
        end
    end

    // Ready and valid look ahead to the next count so that both stay registered.
    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            r_wr_ready <= 1'b0;
            r_rd_valid <= 1'b0;
            r_count    <= 3'd0;
        end else begin
            r_count    <= w_next_count;
            r_wr_ready <= (w_next_count < 3'(DEPTH));
            r_rd_valid <= (w_next_count != 3'd0);
        end
    end

    // ##############################
    // Entry storage
    // ##############################

    generate
        for (genvar i = 0; i < DEPTH; i++) begin : gen_slot
            if (i == DEPTH - 1) begin : gen_tail
                // Nothing sits above the last slot, so only a write changes it.
                assign w_slot_next[i] = (w_wr_xfer && (w_wr_idx == 3'(i))) ? i_wr_data :
                                                                             r_mem[i];
            end else begin : gen_body
                assign w_slot_next[i] = (w_wr_xfer && (w_wr_idx == 3'(i))) ? i_wr_data :
                                        w_rd_xfer                          ? r_mem[i + 1] :
                                                                             r_mem[i];
            end
        end
    endgenerate

    always_ff @(posedge i_axi_aclk) begin
        r_mem <= w_slot_next;
    end

    assign o_wr_ready = r_wr_ready;
    assign o_rd_valid = r_rd_valid;
    assign o_rd_count = r_count;
    assign o_rd_data  = r_mem[0];

endmodule : axi_skid_buffer

`default_nettype wire

// File: src/beat_framer.sv
`timescale 1ns/1ps
`default_nettype none

// Cuts the raw word stream into packets and flags the final beat of each one.
module beat_framer (
    input  wire logic                                 i_axi_aclk,
    input  wire logic                                 i_axi_aresetn,
    input  wire stream_sum_pkg::pkt_len_t             i_pkt_len,

    input  wire logic                                 i_valid,
    output logic                                      o_ready,
    input  wire logic [stream_sum_pkg::DATA_W-1:0]    i_data,

    output logic                                      o_valid,
    input  wire logic                                 i_ready,
    output stream_sum_pkg::beat_t                     o_beat
);

    logic [stream_sum_pkg::CNT_W-1:0] r_idx;
    logic [stream_sum_pkg::CNT_W-1:0] w_target;
    stream_sum_pkg::pkt_len_t         r_len;
    stream_sum_pkg::pkt_len_t         w_len;
    logic                             w_first;
    logic                             w_last;
    logic                             w_xfer;

    assign w_xfer  = i_valid & i_ready;
    assign w_first = (r_idx == '0);

    // The first beat takes its length straight from the input.
    assign w_len    = w_first ? i_pkt_len : r_len;
    assign w_target = (w_len == '0) ? 9'd256 : {1'b0, w_len};
    assign w_last   = ((r_idx + 9'd1) == w_target);

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            r_idx <= '0;
            r_len <= '0;
        end else if (w_xfer) begin
            if (w_first) begin
                r_len <= i_pkt_len;
            end
            r_idx <= w_last ? '0 : (r_idx + 9'd1);
        end
    end

    assign o_valid     = i_valid;
    assign o_ready     = i_ready;
    assign o_beat.data = i_data;
    assign o_beat.last = w_last;

endmodule : beat_framer

`default_nettype wire

// File: src/packet_summer.sv
`timescale 1ns/1ps
`default_nettype none

// Adds up the words of each packet and hands out one result per packet.
module packet_summer (
    input  wire logic                    i_axi_aclk,
    input  wire logic                    i_axi_aresetn,

    input  wire logic                    i_beat_valid,
    output logic                         o_beat_ready,
    input  wire stream_sum_pkg::beat_t   i_beat,

    output logic                         o_res_valid,
    input  wire logic                    i_res_ready,
    output stream_sum_pkg::result_t      o_res
);

    logic [stream_sum_pkg::DATA_W-1:0] r_sum;
    logic [stream_sum_pkg::DATA_W-1:0] w_sum_next;
    logic [stream_sum_pkg::CNT_W-1:0]  r_cnt;
    logic [stream_sum_pkg::CNT_W-1:0]  w_cnt_next;
    logic                              r_res_valid;
    stream_sum_pkg::result_t           r_res;
    logic                              w_beat_xfer;
    logic                              w_res_xfer;
    logic                              w_beat_ready;

    // Input stalls only while a finished result is still waiting.
    assign w_beat_ready = ~r_res_valid | i_res_ready;
    assign w_beat_xfer  = i_beat_valid & w_beat_ready;
    assign w_res_xfer   = r_res_valid & i_res_ready;

    assign w_sum_next = r_sum + i_beat.data;
    assign w_cnt_next = r_cnt + 9'd1;

    // ##############################
    // Accumulators
    // ##############################

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            r_sum       <= '0;
            r_cnt       <= '0;
            r_res_valid <= 1'b0;
        end else begin
            if (w_beat_xfer) begin
                r_sum <= i_beat.last ? '0 : w_sum_next;
                r_cnt <= i_beat.last ? '0 : w_cnt_next;
            end

            if (w_beat_xfer && i_beat.last) begin
                r_res_valid <= 1'b1;
            end else if (w_res_xfer) begin
                r_res_valid <= 1'b0;
            end
        end
    end

    // The result includes the closing beat itself.
    always_ff @(posedge i_axi_aclk) begin
        if (w_beat_xfer && i_beat.last) begin
            r_res.sum   <= w_sum_next;
            r_res.beats <= w_cnt_next;
        end
    end

    assign o_beat_ready = w_beat_ready;
    assign o_res_valid  = r_res_valid;
    assign o_res        = r_res;

endmodule : packet_summer

`default_nettype wire

// File: src/stream_sum_top.sv
`timescale 1ns/1ps
`default_nettype none

// Packet checksum engine.
// Framer and summer are decoupled by a four-deep buffer, and the result port
// is driven from a two-deep buffer.
module stream_sum_top (
    input  wire logic                              i_axi_aclk,
    input  wire logic                              i_axi_aresetn,
    input  wire stream_sum_pkg::pkt_len_t          i_pkt_len,

    input  wire logic                              i_s_valid,
    output logic                                   o_s_ready,
    input  wire logic [stream_sum_pkg::DATA_W-1:0] i_s_data,

    output logic                                   o_res_valid,
    input  wire logic                              i_res_ready,
    output stream_sum_pkg::result_t                o_res,

    output logic [2:0]                             o_beat_fill
);

    logic                    w_frm_valid;
    logic                    w_frm_ready;
    stream_sum_pkg::beat_t   w_frm_beat;

    logic                    w_buf_valid;
    logic                    w_buf_ready;
    stream_sum_pkg::beat_t   w_buf_beat;

    logic                    w_sum_valid;
    logic                    w_sum_ready;
    stream_sum_pkg::result_t w_sum_res;

    beat_framer u_beat_framer (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_pkt_len     (i_pkt_len),
        .i_valid       (i_s_valid),
        .o_ready       (o_s_ready),
        .i_data        (i_s_data),
        .o_valid       (w_frm_valid),
        .i_ready       (w_frm_ready),
        .o_beat        (w_frm_beat)
    );

    axi_skid_buffer #(
        .T     (stream_sum_pkg::beat_t),
        .SKID4 (1)
    ) u_beat_buffer (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr_valid    (w_frm_valid),
        .o_wr_ready    (w_frm_ready),
        .i_wr_data     (w_frm_beat),
        .o_rd_valid    (w_buf_valid),
        .i_rd_ready    (w_buf_ready),
        .o_rd_count    (o_beat_fill),
        .o_rd_data     (w_buf_beat)
    );

    packet_summer u_packet_summer (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_beat_valid  (w_buf_valid),
        .o_beat_ready  (w_buf_ready),
        .i_beat        (w_buf_beat),
        .o_res_valid   (w_sum_valid),
        .i_res_ready   (w_sum_ready),
        .o_res         (w_sum_res)
    );

    // Its fill level is not reported.
    axi_skid_buffer #(
        .T     (stream_sum_pkg::result_t),
        .SKID4 (0)
    ) u_result_buffer (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr_valid    (w_sum_valid),
        .o_wr_ready    (w_sum_ready),
        .i_wr_data     (w_sum_res),
        .o_rd_valid    (o_res_valid),
        .i_rd_ready    (i_res_ready),
        .o_rd_count    (),
        .o_rd_data     (o_res)
    );

endmodule : stream_sum_top

`default_nettype wire

// File: test/tb_stream_sum.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_sum;

    // Largest beat total the tests can send, which sizes the run limit.
    localparam int PLAN_BEATS  = 8 + 20 * 12 + 256 + 20 * 12 + 6 * 3;
    localparam int CYCLE_LIMIT = 20 * PLAN_BEATS + 500;

    logic                              i_axi_aclk;
    logic                              i_axi_aresetn;
    stream_sum_pkg::pkt_len_t          i_pkt_len;
    logic                              i_s_valid;
    logic                              o_s_ready;
    logic [stream_sum_pkg::DATA_W-1:0] i_s_data;
    logic                              o_res_valid;
    logic                              i_res_ready;
    stream_sum_pkg::result_t           o_res;
    logic [2:0]                        o_beat_fill;

    integer                  seed = 61220;
    int                      ready_mode = 0;
    int                      errors = 0;
    int                      results = 0;
    int                      cycles;
    stream_sum_pkg::result_t exp_q[$];

    stream_sum_top i_stream_sum_top (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_pkt_len     (i_pkt_len),
        .i_s_valid     (i_s_valid),
        .o_s_ready     (o_s_ready),
        .i_s_data      (i_s_data),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready),
        .o_res         (o_res),
        .o_beat_fill   (o_beat_fill)
    );

    initial begin
        i_axi_aclk = 1'b0;
        forever #4 i_axi_aclk = ~i_axi_aclk;
    end

    // ##############################
    // Reference model
    // ##############################

    // A packet's result is its word sum modulo 2^32 and its word count.
    function automatic stream_sum_pkg::result_t ref_result(input logic [31:0] words[$]);
        stream_sum_pkg::result_t r;
        logic [31:0]             acc;
        acc = '0;
        foreach (words[k]) begin
            acc = acc + words[k];
        end
        r.sum   = acc;
        r.beats = 9'(words.size());
        return r;
    endfunction

    // ##############################
    // Stimulus helpers
    // ##############################

    // Starts and ends 1 ns after a rising edge. A length field of 0 sends 256 beats.
    task automatic send_packet(input int len_field, input bit gaps);
        logic [31:0] words[$];
        int          n;
        bit          taken;
        n = (len_field == 0) ? 256 : len_field;
        for (int k = 0; k < n; k++) begin
            words.push_back($random(seed));
        end
        exp_q.push_back(ref_result(words));
        foreach (words[k]) begin
            i_pkt_len = 8'(len_field);
            i_s_data  = words[k];
            i_s_valid = 1'b1;
            do begin
                taken = o_s_ready;
                @(posedge i_axi_aclk);
                #1;
            end while (!taken);
            i_s_valid = 1'b0;
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 3) begin
                    @(posedge i_axi_aclk);
                    #1;
                end
            end
        end
    endtask

    task automatic check_idle();
        assert (o_s_ready == 1'b0) else begin
            $display("mismatch at %0t: o_s_ready got %b expected 0", $time, o_s_ready);
            errors++;
        end
        assert (o_res_valid == 1'b0) else begin
            $display("mismatch at %0t: o_res_valid got %b expected 0", $time, o_res_valid);
            errors++;
        end
    endtask

    // Waits for a full input stall, checks that it holds, then releases the output.
    // A stalled beat buffer sits at its depth of four entries.
    task automatic watch_stall();
        do begin
            @(negedge i_axi_aclk);
        end while (o_s_ready);
        repeat (40) begin
            @(negedge i_axi_aclk);
            assert (!o_s_ready) else begin
                $display("mismatch at %0t: o_s_ready got %b expected 0", $time, o_s_ready);
                errors++;
            end
            assert (o_beat_fill == 3'd4) else begin
                $display("mismatch at %0t: o_beat_fill got %0d expected 4",
                         $time, o_beat_fill);
                errors++;
            end
        end
        ready_mode = 0;
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        while (exp_q.size() != 0) begin
            @(posedge i_axi_aclk);
            #1;
        end
        // A few spare cycles catch any extra result.
        repeat (4) begin
            @(posedge i_axi_aclk);
            #1;
        end
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // Output ready: 0 always high, 1 random low cycles, 2 held low.
    initial begin
        i_res_ready = 1'b0;
        forever begin
            @(posedge i_axi_aclk);
            #1;
            case (ready_mode)
                0:       i_res_ready = 1'b1;
                1:       i_res_ready = (($unsigned($random(seed)) % 4) != 0);
                default: i_res_ready = 1'b0;
            endcase
        end
    end

    // ##############################
    // Result comparison
    // ##############################

    initial begin
        stream_sum_pkg::result_t want;
        forever begin
            @(negedge i_axi_aclk);
            if (o_res_valid && i_res_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("%0t: a result came out while none was expected", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    results++;
                    assert (o_res.sum == want.sum) else begin
                        $display("mismatch at %0t: o_res.sum got %h expected %h",
                                 $time, o_res.sum, want.sum);
                        errors++;
                    end
                    assert (o_res.beats == want.beats) else begin
                        $display("mismatch at %0t: o_res.beats got %0d expected %0d",
                                 $time, o_res.beats, want.beats);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_axi_aclk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    // ##############################
    // Test sequence
    // ##############################

    initial begin
        int mark;
        int len;
        i_axi_aresetn = 1'b0;
        i_pkt_len     = '0;
        i_s_valid     = 1'b0;
        i_s_data      = '0;

        mark = errors;
        repeat (8) begin
            @(posedge i_axi_aclk);
            #1;
            check_idle();
        end
        i_axi_aresetn = 1'b1;
        @(negedge i_axi_aclk);
        check_idle();
        @(posedge i_axi_aclk);
        #1;
        end_test(1, "reset state", mark);

        mark = errors;
        repeat (8) send_packet(1, 1'b0);
        end_test(2, "single-beat packets", mark);

        mark = errors;
        repeat (20) begin
            len = 2 + $unsigned($random(seed)) % 11;
            send_packet(len, 1'b0);
        end
        end_test(3, "random lengths, no stalls", mark);

        mark = errors;
        send_packet(0, 1'b0);
        end_test(4, "256-beat packet", mark);

        mark = errors;
        ready_mode = 1;
        repeat (20) begin
            len = 1 + $unsigned($random(seed)) % 12;
            send_packet(len, 1'b1);
        end
        end_test(5, "input gaps and output stalls", mark);
        ready_mode = 0;

        mark = errors;
        ready_mode = 2;
        fork
            repeat (6) send_packet(3, 1'b0);
            watch_stall();
        join
        end_test(6, "long output stall", mark);

        $display("results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_stream_sum

`default_nettype wire

// File: filelist.f
src/stream_sum_pkg.sv
src/axi_skid_buffer.sv
src/beat_framer.sv
src/packet_summer.sv
src/stream_sum_top.sv
test/tb_stream_sum.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and checks the log.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_stream_sum \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
